// ==== filelist.f ====
buffer_cfg_pkg.sv
queue_msg_pkg.sv
page_free_list.sv
queue_states.sv
packet_buffer.sv
enqueue_ctrl.sv
dequeue_ctrl.sv
queue_manager_top.sv
tb_queue_manager.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the queue manager testbench with Verilator, run it, and search the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_queue_manager -o sim_queue_manager

# Pass or fail is decided by the log search below
./obj_dir/sim_queue_manager > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
exit 1

// ==== tb_queue_manager.sv ====
/* Directed tests against a per-queue reference model. Inputs change on the
   falling edge, flags are sampled 1 ns later and registered outputs a cycle later */
`timescale 1ns/100ps

module tb_queue_manager
    import buffer_cfg_pkg::*;
    import queue_msg_pkg::*;
();

    localparam int NQ  = 4;
    localparam int NP  = 8;
    localparam int WPP = 4;

    logic                      enqueue_queue_occupancy_a4l;
    logic                      reset;
    logic                      enq_strobe;
    enq_req_t                  enq_req;
    logic                      deq_strobe;
    logic [MAX_QUEUES_LOG-1:0] deq_queue;
    logic                      deq_valid;
    deq_resp_t                 deq_resp;
    logic                      occ_query_strobe;
    logic [MAX_QUEUES_LOG-1:0] occ_query_queue;
    logic                      occ_valid;
    logic [OCC_BITS-1:0]       occ_bytes;
    logic [NQ-1:0]             queue_empty;
    logic                      enq_drop;
    logic                      deq_underrun;
    logic                      ready_after_init;

    // Reference model per queue
    payload_t model_fifo  [NQ][$];
    int       model_pages [NQ];
    int       model_tail  [NQ];
    int       model_head  [NQ];
    int       model_occ   [NQ];

    // Responses due in the next cycle
    logic        exp_valid;
    logic [3:0]  exp_queue;
    logic [63:0] exp_data;
    logic [3:0]  exp_bytes;
    logic        exp_occ_valid;
    int          exp_occ;
    logic        dec_pending;
    int          dec_queue;
    int          dec_bytes;
    logic        last_drop;
    logic        last_underrun;
    logic        ready_ok;
    string       test_name;
    int          checks;
    int          mismatches;
    int          other_errors;

    queue_manager_top #(
        .NUM_QUEUES(NQ),
        .NUM_PAGES(NP),
        .WORDS_PER_PAGE(WPP)
    ) queue_manager_top_i (.*);

    always #2 enqueue_queue_occupancy_a4l = !enqueue_queue_occupancy_a4l;

    ////////////////////////////////////////
    // Checking and model helpers

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch %s %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("%s: %s", test_name, what);
    endtask

    // Queue has no page or a full tail page
    function automatic logic needs_page(input int q);
        return model_pages[q] == 0 || model_tail[q] == WPP;
    endfunction

    function automatic int free_pages();
        int used;
        used = 0;
        for (int q = 0; q < NQ; q++) begin
            used += model_pages[q];
        end
        return NP - used;
    endfunction

    function automatic logic [NQ-1:0] model_empty();
        logic [NQ-1:0] e;
        for (int q = 0; q < NQ; q++) begin
            e[q] = (model_fifo[q].size() == 0);
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // One clock cycle of stimulus

    task automatic step(input logic do_enq, input int eq, input logic [63:0] ed,
                        input int eb, input logic do_deq, input int dq,
                        input logic do_qry, input int qq);
        logic     need;
        logic     drop;
        logic     underrun;
        payload_t word;
        @(negedge enqueue_queue_occupancy_a4l);
        // Registered answers to the previous cycle
        check("deq_valid", 64'(exp_valid), 64'(deq_valid));
        if (exp_valid) begin
            check("deq_resp.queue", 64'(exp_queue), 64'(deq_resp.queue));
            check("deq_resp.data", exp_data, deq_resp.data);
            check("deq_resp.bytes", 64'(exp_bytes), 64'(deq_resp.bytes));
        end
        check("occ_valid", 64'(exp_occ_valid), 64'(occ_valid));
        if (exp_occ_valid) begin
            check("occ_bytes", 64'(exp_occ), 64'(occ_bytes));
        end
        check("queue_empty", 64'(model_empty()), 64'(queue_empty));
        enq_strobe       = do_enq;
        enq_req.queue    = MAX_QUEUES_LOG'(eq);
        enq_req.data     = ed;
        enq_req.bytes    = BYTE_CNT_BITS'(eb);
        deq_strobe       = do_deq;
        deq_queue        = MAX_QUEUES_LOG'(dq);
        occ_query_strobe = do_qry;
        occ_query_queue  = MAX_QUEUES_LOG'(qq);
        #1;
        // Both sides decide on the state before this cycle
        need          = needs_page(eq);
        drop          = do_enq && need && free_pages() == 0;
        underrun      = do_deq && model_fifo[dq].size() == 0;
        last_drop     = enq_drop;
        last_underrun = deq_underrun;
        check("enq_drop", 64'(drop), 64'(enq_drop));
        check("deq_underrun", 64'(underrun), 64'(deq_underrun));
        exp_occ_valid = do_qry;
        exp_occ       = model_occ[qq];
        exp_valid     = do_deq && !underrun;
        if (exp_valid) begin
            word      = model_fifo[dq].pop_front();
            exp_queue = 4'(dq);
            exp_data  = word.data;
            exp_bytes = word.bytes;
            // Last slot read finishes the head page
            if (model_head[dq] == WPP - 1) begin
                model_head[dq] = 0;
                model_pages[dq]--;
            end else begin
                model_head[dq]++;
            end
        end
        // Decrement of the previous dequeue lands at the end of this cycle
        if (dec_pending) begin
            model_occ[dec_queue] -= dec_bytes;
        end
        dec_pending = exp_valid;
        dec_queue   = dq;
        dec_bytes   = exp_bytes;
        if (do_enq && !drop) begin
            word.data  = ed;
            word.bytes = BYTE_CNT_BITS'(eb);
            model_fifo[eq].push_back(word);
            model_occ[eq] += eb;
            if (need) begin
                model_pages[eq]++;
                model_tail[eq] = 1;
            end else begin
                model_tail[eq]++;
            end
        end
    endtask

    task automatic idle();
        step(1'b0, 0, '0, 0, 1'b0, 0, 1'b0, 0);
    endtask

    task automatic enq_word(input int q, input int bytes);
        step(1'b1, q, {$urandom, $urandom}, bytes, 1'b0, 0, 1'b0, 0);
    endtask

    task automatic deq_word(input int q);
        step(1'b0, 0, '0, 0, 1'b1, q, 1'b0, 0);
    endtask

    task automatic query(input int q);
        step(1'b0, 0, '0, 0, 1'b0, 0, 1'b1, q);
    endtask

    task automatic drain();
        for (int q = 0; q < NQ; q++) begin
            while (model_fifo[q].size() > 0) begin
                deq_word(q);
            end
        end
        idle();
    endtask

    task automatic wait_ready(output logic ok);
        ok = 1'b0;
        for (int cycles = 0; cycles < 4 * NP && !ok; cycles++) begin
            @(negedge enqueue_queue_occupancy_a4l);
            ok = ready_after_init;
        end
        if (!ok) begin
            report_failure("ready_after_init did not rise after reset");
        end
    endtask

    ////////////////////////////////////////
    // Directed tests

    task automatic after_reset_test();
        test_name = "after_reset";
        check("queue_empty all ones", 64'({NQ{1'b1}}), 64'(queue_empty));
        for (int q = 0; q < NQ; q++) begin
            query(q);
        end
        idle();
    endtask

    task automatic order_test();
        test_name = "order";
        for (int i = 0; i < 6; i++) begin
            enq_word(1, $urandom_range(8, 1));
        end
        // One dequeue per cycle and one response each
        for (int i = 0; i < 6; i++) begin
            deq_word(1);
        end
        idle();
        check("queue_empty[1]", 64'(1), 64'(queue_empty[1]));
    endtask

    task automatic occupancy_test();
        int eq;
        int dq;
        test_name = "occupancy";
        for (int i = 0; i < 48; i++) begin
            eq = $urandom_range(NQ - 1, 0);
            // Now and then the dequeue hits the queue being written
            dq = ($urandom_range(3, 0) == 0) ? eq : $urandom_range(NQ - 1, 0);
            step($urandom_range(3, 0) != 0, eq, {$urandom, $urandom}, $urandom_range(8, 1),
                 $urandom_range(1, 0) == 1, dq, 1'b1, $urandom_range(NQ - 1, 0));
        end
        drain();
    endtask

    task automatic chaining_test();
        test_name = "page_chaining";
        for (int r = 0; r < 3; r++) begin
            for (int q = 0; q < NQ; q++) begin
                enq_word(q, $urandom_range(8, 1));
            end
        end
        // Each cycle writes one queue and reads its neighbour
        for (int r = 0; r < 3 * WPP; r++) begin
            for (int q = 0; q < NQ; q++) begin
                step(1'b1, q, {$urandom, $urandom}, $urandom_range(8, 1),
                     1'b1, (q + 1) % NQ, 1'b0, 0);
            end
        end
        drain();
    endtask

    task automatic full_buffer_test();
        int guard;
        test_name = "full_buffer";
        guard = 0;
        while (!(free_pages() == 0 && needs_page(0)) && guard <= NP * WPP) begin
            enq_word(0, 8);
            guard++;
        end
        if (guard > NP * WPP) begin
            report_failure("the buffer never ran out of pages");
        end
        // Word needs a page with none left
        step(1'b1, 0, {$urandom, $urandom}, 5, 1'b0, 0, 1'b1, 0);
        check("enq_drop seen", 64'(1), 64'(last_drop));
        query(0);
        idle();
        // Queue 0 started empty and holds only the full words
        check("occupancy after drop", 64'(8 * guard), 64'(occ_bytes));
        for (int i = 0; i < WPP; i++) begin
            deq_word(0);
        end
        enq_word(0, 3);
        check("enq_drop after release", 64'(0), 64'(last_drop));
        drain();
    endtask

    task automatic underrun_test();
        test_name = "underrun";
        step(1'b0, 0, '0, 0, 1'b1, 2, 1'b1, 2);
        check("deq_underrun seen", 64'(1), 64'(last_underrun));
        for (int window = 0; window < 6; window++) begin
            idle();
            if (deq_valid) begin
                report_failure("deq_valid rose after a dequeue of an empty queue");
            end
        end
        query(2);
        idle();
        check("queue_empty[2]", 64'(1), 64'(queue_empty[2]));
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        enqueue_queue_occupancy_a4l = 1'b0;
        reset            = 1'b1;
        enq_strobe       = 1'b0;
        enq_req          = '0;
        deq_strobe       = 1'b0;
        deq_queue        = '0;
        occ_query_strobe = 1'b0;
        occ_query_queue  = '0;
        exp_valid        = 1'b0;
        exp_occ_valid    = 1'b0;
        dec_pending      = 1'b0;
        checks           = 0;
        mismatches       = 0;
        other_errors     = 0;
        test_name        = "init";
        void'($urandom(32'haf636546));
        repeat (5) @(negedge enqueue_queue_occupancy_a4l);
        reset = 1'b0;
        wait_ready(ready_ok);
        if (ready_ok) begin
            after_reset_test();
            order_test();
            occupancy_test();
            chaining_test();
            full_buffer_test();
            underrun_test();
        end
        finish_run();
    end

endmodule

// ==== queue_manager_top.sv ====
/* All strobes are single-cycle pulses with no back-pressure. Enqueues
   drop until ready_after_init rises after reset */
`timescale 1ns/100ps

module queue_manager_top
    import buffer_cfg_pkg::*;
    import queue_msg_pkg::*;
#(
    parameter int NUM_QUEUES     = 4,
    parameter int NUM_PAGES      = 8,
    parameter int WORDS_PER_PAGE = 4
) (
    input  logic                      enqueue_queue_occupancy_a4l,
    input  logic                      reset,
    input  logic                      enq_strobe,
    input  enq_req_t                  enq_req,
    input  logic                      deq_strobe,
    input  logic [MAX_QUEUES_LOG-1:0] deq_queue,
    output logic                      deq_valid,
    output deq_resp_t                 deq_resp,
    input  logic                      occ_query_strobe,
    input  logic [MAX_QUEUES_LOG-1:0] occ_query_queue,
    output logic                      occ_valid,
    output logic [OCC_BITS-1:0]       occ_bytes,
    output logic [NUM_QUEUES-1:0]     queue_empty,
    output logic                      enq_drop,
    output logic                      deq_underrun,
    output logic                      ready_after_init
);

    ////////////////////////////////////////
    // Internal connections

    logic [MAX_QUEUES_LOG-1:0] tail_lookup_queue;
    logic [MAX_WPP_LOG:0]      tail_ptr;
    logic [MAX_PAGES_LOG-1:0]  tail_page;
    logic [MAX_PAGES_LOG:0]    page_count;
    logic                      tail_update_strobe;
    tail_update_t              tail_update;
    logic                      occ_inc_strobe;
    occ_delta_t                occ_inc;
    logic [MAX_QUEUES_LOG-1:0] head_lookup_queue;
    logic [MAX_WPP_LOG-1:0]    head_ptr;
    logic [MAX_PAGES_LOG-1:0]  head_page;
    logic                      head_empty;
    logic                      head_update_strobe;
    head_update_t              head_update;
    logic                      occ_dec_strobe;
    occ_delta_t                occ_dec;
    logic                      alloc;
    logic [MAX_PAGES_LOG-1:0]  alloc_page;
    logic                      release_en;
    logic [MAX_PAGES_LOG-1:0]  release_page;
    logic                      free_empty;
    logic                      wr_en;
    logic [MAX_PAGES_LOG-1:0]  wr_page;
    logic [MAX_WPP_LOG-1:0]    wr_slot;
    payload_t                  wr_data;
    logic                      rd_en;
    logic [MAX_PAGES_LOG-1:0]  rd_page;
    logic [MAX_WPP_LOG-1:0]    rd_slot;
    payload_t                  rd_data;

    // Port names match the wires above
    page_free_list #(.NUM_PAGES(NUM_PAGES)) page_free_list_i (
        .init_done(ready_after_init),
        .*
    );

    queue_states #(.NUM_QUEUES(NUM_QUEUES), .NUM_PAGES(NUM_PAGES)) queue_states_i (.*);

    packet_buffer #(
        .NUM_PAGES(NUM_PAGES),
        .WORDS_PER_PAGE(WORDS_PER_PAGE)
    ) packet_buffer_i (.*);

    enqueue_ctrl #(.WORDS_PER_PAGE(WORDS_PER_PAGE)) enqueue_ctrl_i (.*);

    dequeue_ctrl #(.WORDS_PER_PAGE(WORDS_PER_PAGE)) dequeue_ctrl_i (.*);

endmodule

// ==== dequeue_ctrl.sv ====
/* One dequeue per cycle. Response and occupancy decrement follow the strobe
   by one cycle. An empty queue gives deq_underrun and no response */
`timescale 1ns/100ps

module dequeue_ctrl
    import buffer_cfg_pkg::*;
    import queue_msg_pkg::*;
#(
    parameter int WORDS_PER_PAGE = 4
) (
    input  logic                      enqueue_queue_occupancy_a4l,
    input  logic                      reset,
    input  logic                      deq_strobe,
    input  logic [MAX_QUEUES_LOG-1:0] deq_queue,
    // Head lookup and update
    output logic [MAX_QUEUES_LOG-1:0] head_lookup_queue,
    input  logic [MAX_WPP_LOG-1:0]    head_ptr,
    input  logic [MAX_PAGES_LOG-1:0]  head_page,
    input  logic                      head_empty,
    output logic                      head_update_strobe,
    output head_update_t              head_update,
    // Page return
    output logic                      release_en,
    output logic [MAX_PAGES_LOG-1:0]  release_page,
    // Buffer read
    output logic                      rd_en,
    output logic [MAX_PAGES_LOG-1:0]  rd_page,
    output logic [MAX_WPP_LOG-1:0]    rd_slot,
    input  payload_t                  rd_data,
    // Response
    output logic                      deq_valid,
    output deq_resp_t                 deq_resp,
    output logic                      occ_dec_strobe,
    output occ_delta_t                occ_dec,
    output logic                      deq_underrun
);

    logic                      go;
    logic                      last_slot;
    logic                      valid_q;
    logic [MAX_QUEUES_LOG-1:0] queue_q;

    assign head_lookup_queue = deq_queue;
    assign deq_underrun      = deq_strobe && head_empty;
    assign go                = deq_strobe && !head_empty;
    assign last_slot         = (head_ptr == MAX_WPP_LOG'(WORDS_PER_PAGE - 1));

    assign head_update_strobe    = go;
    assign head_update.queue     = deq_queue;
    assign head_update.page_done = last_slot;

    // Page is free once its last word has been latched by the read
    assign release_en   = go && last_slot;
    assign release_page = head_page;

    assign rd_en   = go;
    assign rd_page = head_page;
    assign rd_slot = head_ptr;

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= go;
        end
    end

    // Queue index of the read in flight
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (go) begin
            queue_q <= deq_queue;
        end
    end

    assign deq_valid      = valid_q;
    assign deq_resp.queue = queue_q;
    assign deq_resp.data  = rd_data.data;
    assign deq_resp.bytes = rd_data.bytes;

    assign occ_dec_strobe = valid_q;
    assign occ_dec.queue  = queue_q;
    assign occ_dec.bytes  = rd_data.bytes;

endmodule

// ==== enqueue_ctrl.sv ====
/* Accepts one word per cycle with no back-pressure. A word that needs a page
   while the free list is empty is dropped and changes nothing */
`timescale 1ns/100ps

module enqueue_ctrl
    import buffer_cfg_pkg::*;
    import queue_msg_pkg::*;
#(
    parameter int WORDS_PER_PAGE = 4
) (
    input  logic                      enqueue_queue_occupancy_a4l,
    input  logic                      reset,
    input  logic                      enq_strobe,
    input  enq_req_t                  enq_req,
    // Tail lookup
    output logic [MAX_QUEUES_LOG-1:0] tail_lookup_queue,
    input  logic [MAX_WPP_LOG:0]      tail_ptr,
    input  logic [MAX_PAGES_LOG-1:0]  tail_page,
    input  logic [MAX_PAGES_LOG:0]    page_count,
    // Free list
    input  logic                      free_empty,
    input  logic [MAX_PAGES_LOG-1:0]  alloc_page,
    output logic                      alloc,
    // State updates
    output logic                      tail_update_strobe,
    output tail_update_t              tail_update,
    output logic                      occ_inc_strobe,
    output occ_delta_t                occ_inc,
    // Buffer write
    output logic                      wr_en,
    output logic [MAX_PAGES_LOG-1:0]  wr_page,
    output logic [MAX_WPP_LOG-1:0]    wr_slot,
    output payload_t                  wr_data,
    output logic                      enq_drop
);

    localparam int TP_BITS = MAX_WPP_LOG + 1;

    logic need_page;
    logic accept;

    assign tail_lookup_queue = enq_req.queue;

    // Queue without pages or with a full tail page
    assign need_page = (page_count == '0) || (tail_ptr == TP_BITS'(WORDS_PER_PAGE));
    assign enq_drop  = enq_strobe && need_page && free_empty;
    assign accept    = enq_strobe && !enq_drop;
    assign alloc     = accept && need_page;

    assign tail_update_strobe   = accept;
    assign tail_update.queue    = enq_req.queue;
    assign tail_update.tail_ptr = need_page ? TP_BITS'(1) : tail_ptr + 1'b1;
    assign tail_update.new_page = need_page;
    assign tail_update.page     = alloc_page;

    assign occ_inc_strobe = accept;
    assign occ_inc.queue  = enq_req.queue;
    assign occ_inc.bytes  = enq_req.bytes;

    // Slot after the last written word, or slot 0 of the fresh page
    assign wr_en         = accept;
    assign wr_page       = need_page ? alloc_page : tail_page;
    assign wr_slot       = need_page ? '0 : tail_ptr[MAX_WPP_LOG-1:0];
    assign wr_data.data  = enq_req.data;
    assign wr_data.bytes = enq_req.bytes;

    // Free list must not hand out a page this queue still owns
    fresh_page_a: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) alloc && page_count != '0 |-> alloc_page != tail_page)
        else $error("allocated page already in the tail chain");

endmodule

// ==== packet_buffer.sv ====
/* NUM_PAGES and WORDS_PER_PAGE must be powers of two, at least 2.
   Read data appears one cycle after rd_en */
`timescale 1ns/100ps

module packet_buffer
    import buffer_cfg_pkg::*;
    import queue_msg_pkg::*;
#(
    parameter int NUM_PAGES      = 8,
    parameter int WORDS_PER_PAGE = 4
) (
    input  logic                     enqueue_queue_occupancy_a4l,
    input  logic                     wr_en,
    input  logic [MAX_PAGES_LOG-1:0] wr_page,
    input  logic [MAX_WPP_LOG-1:0]   wr_slot,
    input  payload_t                 wr_data,
    input  logic                     rd_en,
    input  logic [MAX_PAGES_LOG-1:0] rd_page,
    input  logic [MAX_WPP_LOG-1:0]   rd_slot,
    output payload_t                 rd_data
);

    localparam int PL = $clog2(NUM_PAGES);
    localparam int WL = $clog2(WORDS_PER_PAGE);

    // Page index in the upper address bits, slot in the lower
    payload_t mem [NUM_PAGES * WORDS_PER_PAGE];

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (wr_en) begin
            mem[{wr_page[PL-1:0], wr_slot[WL-1:0]}] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[{rd_page[PL-1:0], rd_slot[WL-1:0]}];
        end
    end

endmodule

// ==== queue_states.sv ====
/* NUM_QUEUES and NUM_PAGES must be powers of two, at least 2. Lookup outputs
   are combinational and show the state before this cycle's updates */
`timescale 1ns/100ps

module queue_states
    import buffer_cfg_pkg::*;
    import queue_msg_pkg::*;
#(
    parameter int NUM_QUEUES = 4,
    parameter int NUM_PAGES  = 8
) (
    input  logic                      enqueue_queue_occupancy_a4l,
    input  logic                      reset,
    // Tail side
    input  logic [MAX_QUEUES_LOG-1:0] tail_lookup_queue,
    output logic [MAX_WPP_LOG:0]      tail_ptr,
    output logic [MAX_PAGES_LOG-1:0]  tail_page,
    output logic [MAX_PAGES_LOG:0]    page_count,
    input  logic                      tail_update_strobe,
    input  tail_update_t              tail_update,
    input  logic                      occ_inc_strobe,
    input  occ_delta_t                occ_inc,
    // Head side
    input  logic [MAX_QUEUES_LOG-1:0] head_lookup_queue,
    output logic [MAX_WPP_LOG-1:0]    head_ptr,
    output logic [MAX_PAGES_LOG-1:0]  head_page,
    output logic                      head_empty,
    input  logic                      head_update_strobe,
    input  head_update_t              head_update,
    input  logic                      occ_dec_strobe,
    input  occ_delta_t                occ_dec,
    // Occupancy query and flags
    input  logic                      occ_query_strobe,
    input  logic [MAX_QUEUES_LOG-1:0] occ_query_queue,
    output logic                      occ_valid,
    output logic [OCC_BITS-1:0]       occ_bytes,
    output logic [NUM_QUEUES-1:0]     queue_empty
);

    localparam int QL      = $clog2(NUM_QUEUES);
    localparam int CL      = $clog2(NUM_PAGES);
    localparam int PC_BITS = MAX_PAGES_LOG + 1;

    logic [MAX_WPP_LOG:0]     tail_ptrs [NUM_QUEUES];
    logic [MAX_WPP_LOG-1:0]   head_ptrs [NUM_QUEUES];
    logic [PC_BITS-1:0]       page_cnts [NUM_QUEUES];
    logic [OCC_BITS-1:0]      occ       [NUM_QUEUES];
    logic [CL-1:0]            chain_wr  [NUM_QUEUES];
    logic [CL-1:0]            chain_rd  [NUM_QUEUES];
    logic [MAX_PAGES_LOG-1:0] chain     [NUM_QUEUES][NUM_PAGES];

    logic [QL-1:0]         tq;
    logic [QL-1:0]         hq;
    logic [QL-1:0]         uq;
    logic [QL-1:0]         qq;
    logic [QL-1:0]         dq;
    logic [NUM_QUEUES-1:0] tail_hit;
    logic [NUM_QUEUES-1:0] head_hit;
    logic [NUM_QUEUES-1:0] inc_hit;
    logic [NUM_QUEUES-1:0] dec_hit;

    assign tq = tail_lookup_queue[QL-1:0];
    assign hq = head_lookup_queue[QL-1:0];
    assign uq = tail_update.queue[QL-1:0];
    assign qq = occ_query_queue[QL-1:0];
    assign dq = occ_dec.queue[QL-1:0];

    ////////////////////////////////////////
    // Lookups

    // Chain write index points one past the tail page
    assign tail_ptr   = tail_ptrs[tq];
    assign page_count = page_cnts[tq];
    assign tail_page  = chain[tq][chain_wr[tq] - 1'b1];

    assign head_ptr   = head_ptrs[hq];
    assign head_page  = chain[hq][chain_rd[hq]];
    assign head_empty = queue_empty[hq];

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            tail_hit[q] = tail_update_strobe && (tail_update.queue == MAX_QUEUES_LOG'(q));
            head_hit[q] = head_update_strobe && (head_update.queue == MAX_QUEUES_LOG'(q));
            inc_hit[q]  = occ_inc_strobe && (occ_inc.queue == MAX_QUEUES_LOG'(q));
            dec_hit[q]  = occ_dec_strobe && (occ_dec.queue == MAX_QUEUES_LOG'(q));
            // Head meets tail inside the only page left
            queue_empty[q] = (page_cnts[q] == '0) ||
                             (page_cnts[q] == PC_BITS'(1) &&
                              {1'b0, head_ptrs[q]} == tail_ptrs[q]);
        end
    end

    ////////////////////////////////////////
    // Updates

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            tail_ptrs <= '{default: '0};
            head_ptrs <= '{default: '0};
            page_cnts <= '{default: '0};
            occ       <= '{default: '0};
            chain_wr  <= '{default: '0};
            chain_rd  <= '{default: '0};
            occ_valid <= 1'b0;
        end else begin
            occ_valid <= occ_query_strobe;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (tail_hit[q]) begin
                    tail_ptrs[q] <= tail_update.tail_ptr;
                end
                if (tail_hit[q] && tail_update.new_page) begin
                    chain_wr[q] <= chain_wr[q] + 1'b1;
                end
                if (head_hit[q]) begin
                    head_ptrs[q] <= head_update.page_done ? '0 : head_ptrs[q] + 1'b1;
                end
                if (head_hit[q] && head_update.page_done) begin
                    chain_rd[q] <= chain_rd[q] + 1'b1;
                end
                // New page and finished page in one cycle cancel out
                page_cnts[q] <= page_cnts[q]
                              + PC_BITS'(tail_hit[q] && tail_update.new_page)
                              - PC_BITS'(head_hit[q] && head_update.page_done);
                occ[q] <= occ[q]
                        + (inc_hit[q] ? OCC_BITS'(occ_inc.bytes) : '0)
                        - (dec_hit[q] ? OCC_BITS'(occ_dec.bytes) : '0);
            end
        end
    end

    // Chain entries and query data
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (tail_update_strobe && tail_update.new_page) begin
            chain[uq][chain_wr[uq]] <= tail_update.page;
        end
        if (occ_query_strobe) begin
            occ_bytes <= occ[qq];
        end
    end

    // Decrement arrives a cycle after the read while its bytes are still counted
    occ_underflow_a: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) occ_dec_strobe |-> occ[dq] >= OCC_BITS'(occ_dec.bytes))
        else $error("queue occupancy underflow");

    queue_index_a: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset)
        (tail_update_strobe -> tail_update.queue < NUM_QUEUES) &&
        (head_update_strobe -> head_update.queue < NUM_QUEUES) &&
        (occ_query_strobe -> occ_query_queue < NUM_QUEUES))
        else $error("queue index out of range");

endmodule

// ==== page_free_list.sv ====
/* NUM_PAGES must be a power of two, at least 2. The list reports empty for
   NUM_PAGES cycles after reset while it loads every page index */
`timescale 1ns/100ps

module page_free_list
    import buffer_cfg_pkg::*;
#(
    parameter int NUM_PAGES = 8
) (
    input  logic                     enqueue_queue_occupancy_a4l,
    input  logic                     reset,
    input  logic                     alloc,
    output logic [MAX_PAGES_LOG-1:0] alloc_page,
    input  logic                     release_en,
    input  logic [MAX_PAGES_LOG-1:0] release_page,
    output logic                     free_empty,
    output logic                     init_done
);

    localparam int PL = $clog2(NUM_PAGES);
    localparam int CW = PL + 1;

    free_list_state_e         state;
    logic [MAX_PAGES_LOG-1:0] slots [NUM_PAGES];
    logic [PL-1:0]            rd_ptr;
    logic [PL-1:0]            wr_ptr;
    logic [CW-1:0]            count;
    logic                     push;
    logic [MAX_PAGES_LOG-1:0] push_page;

    assign init_done  = (state == FL_RUN);
    assign free_empty = !init_done || (count == '0);
    assign alloc_page = slots[rd_ptr];

    // Fill stores the page indices in order, run stores returned pages
    assign push      = init_done ? release_en : 1'b1;
    assign push_page = init_done ? release_page : MAX_PAGES_LOG'(wr_ptr);

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (push) begin
            slots[wr_ptr] <= push_page;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (reset) begin
            state  <= FL_FILL;
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Allocate and release together leave the count alone
            count <= count + CW'(push) - CW'(alloc);
            if (state == FL_FILL && wr_ptr == PL'(NUM_PAGES - 1)) begin
                state <= FL_RUN;
            end
        end
    end

    ////////////////////////////////////////
    // Checks on the enqueue and dequeue sides

    alloc_not_empty_a: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) alloc |-> !free_empty)
        else $error("page allocated from an empty free list");

    release_not_full_a: assert property (@(posedge enqueue_queue_occupancy_a4l)
        disable iff (reset) release_en |-> init_done && count < CW'(NUM_PAGES))
        else $error("page released into a full free list");

endmodule

// ==== queue_msg_pkg.sv ====
/* Index fields are sized for the package limits. Modules use only the low
   bits that their own parameters need */
package queue_msg_pkg;
    import buffer_cfg_pkg::*;

    // Word and byte count as stored in the buffer
    typedef struct packed {
        logic [WORD_BITS-1:0]     data;
        logic [BYTE_CNT_BITS-1:0] bytes;
    } payload_t;

    typedef struct packed {
        logic [MAX_QUEUES_LOG-1:0] queue;
        logic [WORD_BITS-1:0]      data;
        logic [BYTE_CNT_BITS-1:0]  bytes;
    } enq_req_t;

    typedef struct packed {
        logic [MAX_QUEUES_LOG-1:0] queue;
        logic [WORD_BITS-1:0]      data;
        logic [BYTE_CNT_BITS-1:0]  bytes;
    } deq_resp_t;

    // Tail pointer counts written words, one bit wider than a slot
    typedef struct packed {
        logic [MAX_QUEUES_LOG-1:0] queue;
        logic [MAX_WPP_LOG:0]      tail_ptr;
        logic                      new_page;
        logic [MAX_PAGES_LOG-1:0]  page;
    } tail_update_t;

    typedef struct packed {
        logic [MAX_QUEUES_LOG-1:0] queue;
        logic                      page_done;
    } head_update_t;

    // Enqueue increment or dequeue decrement
    typedef struct packed {
        logic [MAX_QUEUES_LOG-1:0] queue;
        logic [BYTE_CNT_BITS-1:0]  bytes;
    } occ_delta_t;

endpackage

// ==== buffer_cfg_pkg.sv ====
/* Payload words are fixed at 8 bytes. Module parameters must stay within
   16 queues, 256 pages and 64 words per page */
package buffer_cfg_pkg;

    // Payload word
    localparam int BYTES_PER_WORD = 8;
    localparam int WORD_BITS      = BYTES_PER_WORD * 8;
    localparam int BYTE_CNT_BITS  = 4;

    // Field widths for the largest geometry
    localparam int MAX_QUEUES_LOG = 4;
    localparam int MAX_PAGES_LOG  = 8;
    localparam int MAX_WPP_LOG    = 6;

    // Byte occupancy of one queue holding every page of the largest buffer
    localparam int OCC_BITS = MAX_PAGES_LOG + MAX_WPP_LOG + $clog2(BYTES_PER_WORD) + 1;

    // Free list loads its page indices before it serves requests
    typedef enum logic {
        FL_FILL,
        FL_RUN
    } free_list_state_e;

endpackage
